/* build.f */
logic/dataflow_pkg.sv
logic/join_n.sv
logic/skid_buffer.sv
logic/fixed_mac_lane.sv
logic/mac_config_regs.sv
logic/mac_stream_top.sv
verif/mac_stream_asserts.sv
verif/mac_stream_tb.sv

/* logic/dataflow_pkg.sv */
package dataflow_pkg;

  // Width of every operand and of the final result
  localparam int data_w = 16;

  // A full signed product needs twice the operand width
  localparam int prod_w = 2 * data_w;

  // One extra bit so that adding c to the product never overflows
  localparam int sum_w = prod_w + 1;

  // Shift amounts run from 0 to 31
  localparam int shift_w = 5;

  // Width of the register data path seen by software
  localparam int reg_data_w = 8;

  // Number of operand streams that are joined before the lane
  localparam int num_operands = 3;

  typedef logic signed [data_w-1:0] operand_t;
  typedef logic signed [data_w-1:0] result_t;

  // One joined beat, a in the top bits and c in the bottom bits
  typedef struct packed {
    operand_t a;
    operand_t b;
    operand_t c;
  } mac_in_t;

  // Configuration level that steers the lane
  typedef struct packed {
    logic [shift_w-1:0] shift;
    logic               saturate;
  } mac_cfg_t;

  typedef logic [1:0] reg_addr_t;

  // Register map
  localparam reg_addr_t addr_shift = 2'd0;
  localparam reg_addr_t addr_ctrl  = 2'd1;

  // Position of the saturate enable inside the control register
  localparam int ctrl_sat_bit = 0;

endpackage

/* logic/fixed_mac_lane.sv */
module fixed_mac_lane (
  input  logic                  clk,
  input  logic                  rst,

  input  dataflow_pkg::mac_in_t in_data,
  input  logic                  in_valid,
  output logic                  in_ready,

  input  dataflow_pkg::mac_cfg_t cfg,

  output dataflow_pkg::result_t out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  localparam int data_w = dataflow_pkg::data_w;
  localparam int prod_w = dataflow_pkg::prod_w;
  localparam int sum_w  = dataflow_pkg::sum_w;

  // Clamp limits of the result range, written at the width of the sum
  localparam logic signed [sum_w-1:0] res_max =
    {{(sum_w - data_w + 1){1'b0}}, {(data_w - 1){1'b1}}};
  localparam logic signed [sum_w-1:0] res_min =
    {{(sum_w - data_w + 1){1'b1}}, {(data_w - 1){1'b0}}};

  logic signed [prod_w-1:0] product;
  logic signed [sum_w-1:0]  sum;
  logic signed [sum_w-1:0]  shifted;
  dataflow_pkg::result_t    result_next;
  logic                     accept;

  // Full-width signed product, both operands are signed so no bits are lost
  assign product = in_data.a * in_data.b;

  // c is sign-extended by the signed context of the addition
  assign sum = product + in_data.c;

  // Arithmetic shift, which truncates toward negative infinity
  assign shifted = sum >>> cfg.shift;

  // Saturate clamps to the result range, otherwise the low bits are kept
  always_comb begin
    if (cfg.saturate && (shifted > res_max)) begin
      result_next = res_max[data_w-1:0];
    end else if (cfg.saturate && (shifted < res_min)) begin
      result_next = res_min[data_w-1:0];
    end else begin
      result_next = shifted[data_w-1:0];
    end
  end

  // A new beat is taken when the output register is empty or being emptied
  assign in_ready = ~out_valid | out_ready;
  assign accept   = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // The configuration is captured together with the operands it applies to
  always_ff @(posedge clk) begin
    if (accept) begin
      out_data <= result_next;
    end
  end

  // With out_ready low and a result held, in_ready stays low,
  // so the result register cannot be overwritten before its transfer

endmodule

/* logic/join_n.sv */
module join_n #(
  parameter int NUM_HANDSHAKES = 3
) (
  input  logic [NUM_HANDSHAKES-1:0] data_in_valid,
  output logic [NUM_HANDSHAKES-1:0] data_in_ready,
  output logic                      data_out_valid,
  input  logic                      data_out_ready
);

  // High once every upstream handshake presents a beat
  logic all_valid;

  assign all_valid = &data_in_valid;

  // A joined beat exists only when all inputs have arrived
  assign data_out_valid = all_valid;

  // Ready per input follows two cases
  // With the full set present, every input moves together with the downstream ready
  // With the set incomplete, inputs that already hold a beat are stalled
  // Inputs still waiting see the downstream ready so they are not blocked for no reason
  always_comb begin
    for (int i = 0; i < NUM_HANDSHAKES; i++) begin
      if (all_valid) begin
        data_in_ready[i] = data_out_ready;
      end else begin
        // An early arrival keeps its beat until the rest catch up
        data_in_ready[i] = data_out_ready & ~data_in_valid[i];
      end
    end
  end

  // Note that a stalled input never sees ready while valid,
  // so no beat of a partial set can be consumed on its own

endmodule

/* logic/mac_config_regs.sv */
module mac_config_regs #(
  parameter int unsigned SHIFT_RESET = 0
) (
  input  logic                                  clk,
  input  logic                                  rst,

  input  logic                                  cfg_wr,
  input  dataflow_pkg::reg_addr_t               cfg_addr,
  input  logic [dataflow_pkg::reg_data_w-1:0]   cfg_wdata,
  output logic [dataflow_pkg::reg_data_w-1:0]   cfg_rdata,

  output dataflow_pkg::mac_cfg_t                cfg
);

  localparam int shift_w = dataflow_pkg::shift_w;
  localparam int sat_bit = dataflow_pkg::ctrl_sat_bit;

  // Both registers live directly in the configuration struct
  // that drives the lane
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.shift    <= SHIFT_RESET[shift_w-1:0];
      cfg.saturate <= 1'b0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        dataflow_pkg::addr_shift: begin
          // Only the low bits of the written byte hold a shift amount
          cfg.shift <= cfg_wdata[shift_w-1:0];
        end
        dataflow_pkg::addr_ctrl: begin
          cfg.saturate <= cfg_wdata[sat_bit];
        end
        default: begin
          // writes to unmapped addresses are ignored
        end
      endcase
    end
  end

  // Readback is combinational from the addressed register
  // Undefined bits and unmapped addresses read as zero
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      dataflow_pkg::addr_shift: begin
        cfg_rdata[shift_w-1:0] = cfg.shift;
      end
      dataflow_pkg::addr_ctrl: begin
        cfg_rdata[sat_bit] = cfg.saturate;
      end
      default: begin
        cfg_rdata = '0;
      end
    endcase
  end

endmodule

/* logic/mac_stream_top.sv */
module mac_stream_top #(
  parameter int unsigned SHIFT_RESET = 0
) (
  input  logic                                clk,
  input  logic                                rst,

  input  dataflow_pkg::operand_t              a_data,
  input  logic                                a_valid,
  output logic                                a_ready,
  input  dataflow_pkg::operand_t              b_data,
  input  logic                                b_valid,
  output logic                                b_ready,
  input  dataflow_pkg::operand_t              c_data,
  input  logic                                c_valid,
  output logic                                c_ready,

  output dataflow_pkg::result_t               out_data,
  output logic                                out_valid,
  input  logic                                out_ready,

  input  logic                                cfg_wr,
  input  dataflow_pkg::reg_addr_t             cfg_addr,
  input  logic [dataflow_pkg::reg_data_w-1:0] cfg_wdata,
  output logic [dataflow_pkg::reg_data_w-1:0] cfg_rdata
);

  localparam int num_ops = dataflow_pkg::num_operands;

  // Buffered operand streams in front of the join
  dataflow_pkg::operand_t a_q_data, b_q_data, c_q_data;
  logic                   a_q_valid, b_q_valid, c_q_valid;

  // Join handshake, bit 0 is a, bit 1 is b and bit 2 is c
  logic [num_ops-1:0]     join_valid;
  logic [num_ops-1:0]     join_ready;
  logic                   mac_valid;
  logic                   mac_ready;
  dataflow_pkg::mac_in_t  mac_data;

  // Lane result stream into the output buffer
  dataflow_pkg::result_t  lane_data;
  logic                   lane_valid;
  logic                   lane_ready;

  dataflow_pkg::mac_cfg_t cfg;

  assign join_valid = {c_q_valid, b_q_valid, a_q_valid};

  // The operands are packed into one beat beside the join
  assign mac_data = '{a: a_q_data, b: b_q_data, c: c_q_data};

  skid_buffer #(.payload_t(dataflow_pkg::operand_t)) u_a_buf (
    .clk(clk), .rst(rst),
    .in_data(a_data), .in_valid(a_valid), .in_ready(a_ready),
    .out_data(a_q_data), .out_valid(a_q_valid), .out_ready(join_ready[0])
  );

  skid_buffer #(.payload_t(dataflow_pkg::operand_t)) u_b_buf (
    .clk(clk), .rst(rst),
    .in_data(b_data), .in_valid(b_valid), .in_ready(b_ready),
    .out_data(b_q_data), .out_valid(b_q_valid), .out_ready(join_ready[1])
  );

  skid_buffer #(.payload_t(dataflow_pkg::operand_t)) u_c_buf (
    .clk(clk), .rst(rst),
    .in_data(c_data), .in_valid(c_valid), .in_ready(c_ready),
    .out_data(c_q_data), .out_valid(c_q_valid), .out_ready(join_ready[2])
  );

  join_n #(.NUM_HANDSHAKES(num_ops)) u_join (
    .data_in_valid(join_valid), .data_in_ready(join_ready),
    .data_out_valid(mac_valid), .data_out_ready(mac_ready)
  );

  fixed_mac_lane u_lane (
    .clk(clk), .rst(rst),
    .in_data(mac_data), .in_valid(mac_valid), .in_ready(mac_ready),
    .cfg(cfg),
    .out_data(lane_data), .out_valid(lane_valid), .out_ready(lane_ready)
  );

  // Output buffer keeps the top-level ready path off the lane
  skid_buffer #(.payload_t(dataflow_pkg::result_t)) u_out_buf (
    .clk(clk), .rst(rst),
    .in_data(lane_data), .in_valid(lane_valid), .in_ready(lane_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
  );

  mac_config_regs #(.SHIFT_RESET(SHIFT_RESET)) u_regs (
    .clk(clk), .rst(rst),
    .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
    .cfg(cfg)
  );

endmodule

/* logic/skid_buffer.sv */
module skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,

  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // Skid entry that catches a beat accepted while the main entry is stalled
  payload_t skid_data;
  logic     skid_valid;

  // Registered copy of the input ready so the upstream path starts at a flop
  logic     in_ready_q;

  logic     in_fire;
  logic     main_load;

  assign in_fire = in_valid & in_ready_q;

  // The main entry can take new data when it is empty or being drained
  assign main_load = ~out_valid | out_ready;

  assign in_ready = in_ready_q;

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready_q <= 1'b1;
    end else if (main_load) begin
      if (skid_valid) begin
        // The skid beat is older and must leave before anything new
        out_valid  <= 1'b1;
        skid_valid <= 1'b0;
        in_ready_q <= 1'b1;
      end else begin
        out_valid <= in_fire;
      end
    end else if (in_fire) begin
      // Main entry is stalled, so park the arrival and close the input
      skid_valid <= 1'b1;
      in_ready_q <= 1'b0;
    end
  end

  // Payload registers follow the same decisions and carry no reset
  always_ff @(posedge clk) begin
    if (main_load) begin
      if (skid_valid) begin
        out_data <= skid_data;
      end else if (in_fire) begin
        out_data <= in_data;
      end
    end else if (in_fire) begin
      skid_data <= in_data;
    end
  end

  // While the skid entry is full in_ready_q is low, so a beat can
  // never arrive in the same cycle that the skid entry moves forward

endmodule

/* verif/mac_stream_asserts.sv */
module mac_stream_asserts (
  input  logic                  clk,
  input  logic                  rst,
  input  dataflow_pkg::result_t out_data,
  input  logic                  out_valid,
  input  logic                  out_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures, read by the testbench for its summary
  int assert_errs = 0;

  // A stalled result must keep its payload until it is taken
  property data_held;
    @(posedge clk) disable iff (rst) (out_valid && !out_ready) |=> $stable(out_data);
  endproperty

  // Once raised, valid stays up until the transfer
  property valid_held;
    @(posedge clk) disable iff (rst) (out_valid && !out_ready) |=> out_valid;
  endproperty

  // The output handshake must always be a clean level outside reset
  property valid_known;
    @(posedge clk) disable iff (rst) !$isunknown(out_valid);
  endproperty

  data_held_chk: assert property (data_held) else begin
    assert_errs++;
    $error("out_data changed while out_valid waited for out_ready");
  end

  valid_held_chk: assert property (valid_held) else begin
    assert_errs++;
    $error("out_valid dropped before its beat was taken");
  end

  valid_known_chk: assert property (valid_known) else begin
    assert_errs++;
    $error("out_valid is unknown after reset");
  end

endmodule

// Attach the output handshake checks to every instance of the top level
bind mac_stream_top mac_stream_asserts u_asserts (
  .clk(clk), .rst(rst),
  .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
);

/* verif/mac_stream_tb.sv */
module mac_stream_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 8;
  localparam int num_rows     = 20;
  localparam int num_ops      = dataflow_pkg::num_operands;
  // The segment that starts at this row runs with the c stream held back
  localparam int skew_row     = 16;
  localparam int c_delay      = 16;
  localparam int hold_check   = 12;
  // Each row gets 40 cycles, plus the reset time
  localparam longint watchdog_ns = longint'(num_rows * 40 + reset_cycles) * clk_period;

  // One stimulus row with the result that the lane rule gives for it
  typedef struct packed {
    dataflow_pkg::operand_t           a;
    dataflow_pkg::operand_t           b;
    dataflow_pkg::operand_t           c;
    logic [dataflow_pkg::shift_w-1:0] shift;
    logic                             saturate;
    dataflow_pkg::result_t            expected;
  } row_t;

  logic                                clk;
  logic                                rst;
  // Index 0 is a, 1 is b and 2 is c
  dataflow_pkg::operand_t              in_data [num_ops];
  logic [num_ops-1:0]                  in_valid;
  logic [num_ops-1:0]                  in_ready;
  dataflow_pkg::result_t               out_data;
  logic                                out_valid;
  logic                                out_ready;
  logic                                cfg_wr;
  dataflow_pkg::reg_addr_t             cfg_addr;
  logic [dataflow_pkg::reg_data_w-1:0] cfg_wdata;
  logic [dataflow_pkg::reg_data_w-1:0] cfg_rdata;

  row_t rows [num_rows];
  int   seed       = 32'hadb4_8563;
  int   value_errs = 0;
  int   other_errs = 0;

  mac_stream_top #(.SHIFT_RESET(0)) u_dut (
    .clk(clk), .rst(rst),
    .a_data(in_data[0]), .a_valid(in_valid[0]), .a_ready(in_ready[0]),
    .b_data(in_data[1]), .b_valid(in_valid[1]), .b_ready(in_ready[1]),
    .c_data(in_data[2]), .c_valid(in_valid[2]), .c_ready(in_ready[2]),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
    .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Reference rule: full product plus c, arithmetic shift, then clamp or wrap
  function automatic dataflow_pkg::result_t mac_model(
    input dataflow_pkg::operand_t a,
    input dataflow_pkg::operand_t b,
    input dataflow_pkg::operand_t c,
    input int                     shift,
    input logic                   saturate
  );
    longint full;
    longint lim_hi;
    longint lim_lo;
    lim_hi = (longint'(1) << (dataflow_pkg::data_w - 1)) - 1;
    lim_lo = -(longint'(1) << (dataflow_pkg::data_w - 1));
    full = longint'(a) * longint'(b) + longint'(c);
    full = full >>> shift;
    if (saturate && full > lim_hi) begin
      full = lim_hi;
    end else if (saturate && full < lim_lo) begin
      full = lim_lo;
    end
    return full[dataflow_pkg::data_w-1:0];
  endfunction

  function automatic row_t make_row(
    input logic [15:0] a,
    input logic [15:0] b,
    input logic [15:0] c,
    input int          shift,
    input logic        saturate
  );
    row_t r;
    r.a        = a;
    r.b        = b;
    r.c        = c;
    r.shift    = shift[dataflow_pkg::shift_w-1:0];
    r.saturate = saturate;
    r.expected = mac_model(a, b, c, shift, saturate);
    return r;
  endfunction

  task automatic load_table();
    // Wrap with shift 0, overflowing products keep their low bits
    rows[0]  = make_row(16'h0003, 16'h0004, 16'h0005, 0, 1'b0);
    rows[1]  = make_row(16'hfffe, 16'h0007, 16'h0001, 0, 1'b0);
    rows[2]  = make_row(16'h7fff, 16'h7fff, 16'h0000, 0, 1'b0);
    rows[3]  = make_row(16'h8000, 16'h8000, 16'h0000, 0, 1'b0);
    // Wrap with shift 4, negative sums round toward minus infinity
    rows[4]  = make_row(16'h0100, 16'h0100, 16'h0010, 4, 1'b0);
    rows[5]  = make_row(16'hff00, 16'h0003, 16'h0000, 4, 1'b0);
    rows[6]  = make_row(16'h1234, 16'h0010, 16'h0005, 4, 1'b0);
    // Saturate with shift 0 hits both extremes
    rows[7]  = make_row(16'h7fff, 16'h0002, 16'h0000, 0, 1'b1);
    rows[8]  = make_row(16'h8000, 16'h0002, 16'h0000, 0, 1'b1);
    rows[9]  = make_row(16'h0010, 16'h0010, 16'hfff0, 0, 1'b1);
    rows[10] = make_row(16'h4000, 16'h0100, 16'h0000, 8, 1'b1);
    rows[11] = make_row(16'h7fff, 16'h7fff, 16'h7fff, 8, 1'b1);
    rows[12] = make_row(16'h8000, 16'h7fff, 16'h8000, 8, 1'b1);
    // Shift 31 leaves only the sign
    rows[13] = make_row(16'h8000, 16'h8000, 16'h7fff, 31, 1'b1);
    rows[14] = make_row(16'h8000, 16'h7fff, 16'h0000, 31, 1'b1);
    rows[15] = make_row(16'h0005, 16'h0003, 16'hfff0, 31, 1'b1);
    // Skewed segment in wrap mode
    rows[16] = make_row(16'h0009, 16'h0009, 16'h0001, 2, 1'b0);
    rows[17] = make_row(16'hfffd, 16'h0005, 16'h0000, 2, 1'b0);
    rows[18] = make_row(16'h0100, 16'h0100, 16'h0000, 2, 1'b0);
    rows[19] = make_row(16'h7fff, 16'h7fff, 16'h0000, 2, 1'b0);
  endtask

  task automatic compare_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("ERR %s: got %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      other_errs++;
      $display("%s at %0t ns", what, $time);
    end
  endtask

  // Idle cycles before a beat, mostly zero
  function automatic int gap_cycles();
    int r;
    r = $random(seed);
    return r[0] ? 0 : int'(r[2:1]);
  endfunction

  function automatic dataflow_pkg::operand_t operand_of(input int which, input int idx);
    if (which == 0) begin
      return rows[idx].a;
    end else if (which == 1) begin
      return rows[idx].b;
    end
    return rows[idx].c;
  endfunction

  task automatic write_reg(input dataflow_pkg::reg_addr_t addr, input logic [7:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr    = 1'b0;
    cfg_wdata = '0;
  endtask

  // Readback is combinational, so it is sampled one falling edge later
  task automatic check_reg(input dataflow_pkg::reg_addr_t addr, input logic [7:0] exp);
    @(negedge clk);
    cfg_addr = addr;
    @(negedge clk);
    compare_word("cfg_rdata", 16'(cfg_rdata), 16'(exp));
  endtask

  // Ready comes from a flop, so its value at the falling edge holds for the next rising edge
  task automatic drive_operand(input int which, input int first, input int last,
                               input bit use_gaps, input int delay);
    @(negedge clk);
    repeat (delay) @(negedge clk);
    for (int i = first; i <= last; i++) begin
      if (use_gaps) begin
        repeat (gap_cycles()) @(negedge clk);
      end
      in_valid[which] = 1'b1;
      in_data[which]  = operand_of(which, i);
      while (in_ready[which] !== 1'b1) @(negedge clk);
      @(negedge clk);
      in_valid[which] = 1'b0;
      in_data[which]  = '0;
    end
  endtask

  // Random back-pressure; a beat counts when valid and ready meet at the next rising edge
  task automatic collect_results(input int first, input int last);
    int idx;
    int r;
    idx = first;
    while (idx <= last) begin
      @(negedge clk);
      r = $random(seed);
      out_ready = (r[1:0] != 2'b00);
      if (out_valid === 1'b1 && out_ready) begin
        compare_word("out_data", out_data, rows[idx].expected);
        idx++;
      end
    end
  endtask

  // With c missing, a and b back up into their buffers and close their inputs
  task automatic watch_hold();
    repeat (hold_check) @(negedge clk);
    require(in_ready[0] === 1'b0, "a_ready stayed high while the join waited for c");
    require(in_ready[1] === 1'b0, "b_ready stayed high while the join waited for c");
    require(out_valid === 1'b0, "out_valid rose before the c operand arrived");
  endtask

  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("tests failed");
    $finish;
  end

  initial begin
    int first;
    int last;
    bit skew;
    int total;
    rst       = 1'b1;
    in_valid  = '0;
    in_data   = '{default: '0};
    out_ready = 1'b0;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    load_table();
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // State right after reset
    require(out_valid === 1'b0, "out_valid was not low after reset");
    require(in_ready === 3'b111, "an input ready was not high after reset");
    check_reg(dataflow_pkg::addr_shift, 8'h00);
    check_reg(dataflow_pkg::addr_ctrl, 8'h00);

    // Readback keeps only the defined bits, unmapped addresses read zero
    write_reg(dataflow_pkg::addr_shift, 8'hff);
    check_reg(dataflow_pkg::addr_shift, 8'h1f);
    write_reg(dataflow_pkg::addr_ctrl, 8'hff);
    check_reg(dataflow_pkg::addr_ctrl, 8'h01);
    write_reg(2'd2, 8'ha5);
    check_reg(2'd2, 8'h00);
    check_reg(2'd3, 8'h00);

    // Each run of rows with one configuration is written while the pipeline is empty
    first = 0;
    while (first < num_rows) begin
      last = first;
      while (last + 1 < num_rows && rows[last+1].shift == rows[first].shift &&
             rows[last+1].saturate == rows[first].saturate) begin
        last++;
      end
      skew = (first == skew_row);
      write_reg(dataflow_pkg::addr_shift, 8'(rows[first].shift));
      write_reg(dataflow_pkg::addr_ctrl, {7'b0, rows[first].saturate});
      fork
        drive_operand(0, first, last, !skew, 0);
        drive_operand(1, first, last, !skew, 0);
        drive_operand(2, first, last, 1'b1, skew ? c_delay : 0);
        collect_results(first, last);
        begin
          if (skew) begin
            watch_hold();
          end
        end
      join
      first = last + 1;
    end

    // Drain, nothing more may come out and the inputs open again
    @(negedge clk);
    out_ready = 1'b1;
    repeat (6) begin
      @(negedge clk);
      require(out_valid === 1'b0, "out_valid rose after the last result");
    end
    require(in_ready === 3'b111, "an input ready did not return high after the drain");

    total = value_errs + other_errs + u_dut.u_asserts.assert_errs;
    $display("errors: %0d value, %0d other, %0d assertion",
             value_errs, other_errs, u_dut.u_asserts.assert_errs);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
